/* lkp_params.svh */
`ifndef LKP_PARAMS_SVH
`define LKP_PARAMS_SVH

// execute side fields
`define LKP_INFO_W          20
`define LKP_RSLT_W          20
`define LKP_ORDER_W         3
`define LKP_REG_W           5
`define LKP_ROB_W           4

// module A side
`define LKP_REQ_ID_W        10

// storage sizes
`define LKP_MSHR_NUM        8
`define LKP_MSHR_W          3
`define LKP_TAG_NUM         16
`define LKP_TAG_W           4
`define LKP_C2A_DEPTH_LOG2  2
`define LKP_OUT_DEPTH_LOG2  2

`endif

/* lkp_pkg.sv */
`default_nettype none

`include "lkp_params.svh"

package lkp_pkg;

    typedef logic [`LKP_MSHR_W-1:0] mshr_idx_t;

    // bookkeeping carried alongside every lookup
    typedef struct packed {
        logic [`LKP_ORDER_W-1:0] order_id;
        logic                    so;
        logic [`LKP_REG_W-1:0]   reg_entry;
        logic [`LKP_ROB_W-1:0]   rob_entry;
    } lkp_meta_t;

    typedef struct packed {
        logic [`LKP_INFO_W-1:0] key;
        lkp_meta_t              meta;
    } lkp_req_t;

    typedef struct packed {
        logic [`LKP_RSLT_W-1:0] result;
        lkp_meta_t              meta;
    } lkp_rsp_t;

    // request toward module A tagged by its mshr slot
    typedef struct packed {
        logic [`LKP_INFO_W-1:0] key;
        mshr_idx_t              idx;
    } c2a_req_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_SEARCH,
        S_RESOLVE
    } slot_state_e;

endpackage

`default_nettype wire

/* sync_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH      = 8,
    parameter int DEPTH_LOG2 = 2
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              wr_en_i,
    input  wire  [WIDTH-1:0] wr_data_i,
    input  wire              rd_en_i,
    output logic [WIDTH-1:0] rd_data_o,
    output logic             full_o,
    output logic             empty_o
);

    logic [WIDTH-1:0]    mem [2**DEPTH_LOG2];
    logic [DEPTH_LOG2:0] wr_ptr_q;
    logic [DEPTH_LOG2:0] rd_ptr_q;
    logic                do_wr;
    logic                do_rd;

    // extra pointer bit tells full from empty
    assign empty_o = (wr_ptr_q == rd_ptr_q);
    assign full_o  = (wr_ptr_q[DEPTH_LOG2] != rd_ptr_q[DEPTH_LOG2]) &&
                     (wr_ptr_q[DEPTH_LOG2-1:0] == rd_ptr_q[DEPTH_LOG2-1:0]);

    assign do_wr     = wr_en_i && !full_o;
    assign do_rd     = rd_en_i && !empty_o;
    assign rd_data_o = mem[rd_ptr_q[DEPTH_LOG2-1:0]];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr_q[DEPTH_LOG2-1:0]] <= wr_data_i;
        end
    end

endmodule

`default_nettype wire

/* tag_table.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lkp_params.svh"

module tag_table (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    search_i,
    input  wire  [`LKP_INFO_W-1:0] search_key_i,
    output logic                   hit_o,
    output logic [`LKP_RSLT_W-1:0] result_o,
    input  wire                    insert_i,
    input  wire  [`LKP_INFO_W-1:0] insert_key_i,
    input  wire  [`LKP_RSLT_W-1:0] insert_result_i,
    output logic                   insert_done_o
);

    logic [`LKP_TAG_NUM-1:0] vld_q;
    logic [`LKP_INFO_W-1:0]  key_q  [`LKP_TAG_NUM];
    logic [`LKP_RSLT_W-1:0]  rslt_q [`LKP_TAG_NUM];
    logic [`LKP_TAG_W-1:0]   victim_q;
    logic                    srch_hit;
    logic [`LKP_RSLT_W-1:0]  srch_rslt;
    logic                    ins_hit;
    logic [`LKP_TAG_W-1:0]   ins_idx;

    // compare both ports against every valid entry
    always_comb begin
        srch_hit  = 1'b0;
        srch_rslt = '0;
        ins_hit   = 1'b0;
        ins_idx   = victim_q;
        for (int i = 0; i < `LKP_TAG_NUM; i++) begin
            if (vld_q[i] && key_q[i] == search_key_i) begin
                srch_hit  = 1'b1;
                srch_rslt = rslt_q[i];
            end
            if (vld_q[i] && key_q[i] == insert_key_i) begin
                ins_hit = 1'b1;
                ins_idx = i[`LKP_TAG_W-1:0];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_q         <= '0;
            victim_q      <= '0;
            hit_o         <= 1'b0;
            insert_done_o <= 1'b0;
        end else begin
            insert_done_o <= insert_i;
            // search result is held until the next search
            if (search_i) begin
                hit_o <= srch_hit;
            end
            if (insert_i) begin
                vld_q[ins_idx] <= 1'b1;
                if (!ins_hit) begin
                    victim_q <= victim_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (search_i) begin
            result_o <= srch_rslt;
        end
        if (insert_i) begin
            key_q[ins_idx]  <= insert_key_i;
            rslt_q[ins_idx] <= insert_result_i;
        end
    end

endmodule

`default_nettype wire

/* mshr_file.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lkp_params.svh"

module mshr_file (
    input  wire                     clk,
    input  wire                     rst,
    input  wire  [`LKP_INFO_W-1:0]  lookup_key_i,
    output logic                    pending_o,
    output logic                    free_o,
    output lkp_pkg::mshr_idx_t      free_idx_o,
    input  wire                     alloc_i,
    input  wire  lkp_pkg::lkp_req_t alloc_req_i,
    input  wire                     rsp_vld_i,
    input  wire  lkp_pkg::mshr_idx_t rsp_idx_i,
    input  wire  [`LKP_RSLT_W-1:0]  rsp_rslt_i,
    output logic                    insert_o,
    output logic [`LKP_INFO_W-1:0]  insert_key_o,
    output logic [`LKP_RSLT_W-1:0]  insert_result_o,
    input  wire                     insert_done_i,
    output logic                    send_valid_o,
    output lkp_pkg::lkp_rsp_t       send_rsp_o,
    input  wire                     send_accept_i
);

    import lkp_pkg::*;

    logic [`LKP_MSHR_NUM-1:0] vld_q;
    logic [`LKP_MSHR_NUM-1:0] rdy_q;
    logic [`LKP_MSHR_NUM-1:0] ins_q;
    logic [`LKP_MSHR_NUM-1:0] sent_q;
    lkp_req_t                 req_q  [`LKP_MSHR_NUM];
    logic [`LKP_RSLT_W-1:0]   rslt_q [`LKP_MSHR_NUM];
    logic                     ins_busy_q;
    mshr_idx_t                ins_idx_q;
    logic [`LKP_MSHR_NUM-1:0] match_w;
    logic [`LKP_MSHR_NUM-1:0] done_w;
    logic [`LKP_MSHR_NUM-1:0] ready_w;
    mshr_idx_t                pick_idx;

    function automatic mshr_idx_t first_set(input logic [`LKP_MSHR_NUM-1:0] vec);
        mshr_idx_t idx;
        idx = '0;
        for (int i = `LKP_MSHR_NUM - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = i[`LKP_MSHR_W-1:0];
            end
        end
        return idx;
    endfunction

    // ----------------------------------------------------------
    // lookup side
    // ----------------------------------------------------------
    always_comb begin
        for (int i = 0; i < `LKP_MSHR_NUM; i++) begin
            match_w[i] = vld_q[i] && (req_q[i].key == lookup_key_i);
        end
    end

    assign pending_o  = |match_w;
    assign free_o     = |(~vld_q);
    assign free_idx_o = first_set(~vld_q);

    // ----------------------------------------------------------
    // fill and return in lowest ready index order
    // ----------------------------------------------------------
    assign done_w   = vld_q & ins_q & sent_q;
    assign ready_w  = vld_q & rdy_q & ~done_w;
    assign pick_idx = first_set(ready_w);

    assign insert_o        = (|ready_w) && !ins_q[pick_idx] && !ins_busy_q;
    assign insert_key_o    = req_q[pick_idx].key;
    assign insert_result_o = rslt_q[pick_idx];

    assign send_valid_o      = (|ready_w) && !sent_q[pick_idx];
    assign send_rsp_o.result = rslt_q[pick_idx];
    assign send_rsp_o.meta   = req_q[pick_idx].meta;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_q      <= '0;
            rdy_q      <= '0;
            ins_q      <= '0;
            sent_q     <= '0;
            ins_busy_q <= 1'b0;
            ins_idx_q  <= '0;
        end else begin
            // entry is released once inserted and sent
            vld_q  <= vld_q & ~done_w;
            rdy_q  <= rdy_q & ~done_w;
            ins_q  <= ins_q & ~done_w;
            sent_q <= sent_q & ~done_w;
            if (alloc_i) begin
                vld_q[free_idx_o] <= 1'b1;
            end
            if (rsp_vld_i) begin
                rdy_q[rsp_idx_i] <= 1'b1;
            end
            if (insert_o) begin
                ins_busy_q <= 1'b1;
                ins_idx_q  <= pick_idx;
            end
            if (insert_done_i) begin
                ins_busy_q       <= 1'b0;
                ins_q[ins_idx_q] <= 1'b1;
            end
            if (send_accept_i) begin
                sent_q[pick_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            req_q[free_idx_o] <= alloc_req_i;
        end
        if (rsp_vld_i) begin
            rslt_q[rsp_idx_i] <= rsp_rslt_i;
        end
    end

endmodule

`default_nettype wire

/* lookup_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lkp_params.svh"

module lookup_ctrl (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      req_valid_i,
    input  wire  lkp_pkg::lkp_req_t  req_i,
    output logic                     req_ready_o,
    output logic                     search_o,
    output logic [`LKP_INFO_W-1:0]   search_key_o,
    input  wire                      hit_i,
    input  wire  [`LKP_RSLT_W-1:0]   result_i,
    input  wire                      pending_i,
    input  wire                      free_i,
    input  wire  lkp_pkg::mshr_idx_t free_idx_i,
    output logic                     alloc_o,
    output lkp_pkg::lkp_req_t        alloc_req_o,
    output logic                     c2a_push_o,
    output lkp_pkg::c2a_req_t        c2a_data_o,
    input  wire                      c2a_full_i,
    input  wire                      send_valid_i,
    input  wire  lkp_pkg::lkp_rsp_t  send_rsp_i,
    output logic                     send_accept_o,
    output logic                     out_push_o,
    output lkp_pkg::lkp_rsp_t        out_data_o,
    input  wire                      out_full_i
);

    import lkp_pkg::*;

    slot_state_e state_q;
    slot_state_e state_d;
    lkp_req_t    slot_q;
    logic        hit_wr;

    assign req_ready_o  = (state_q == S_IDLE);
    assign search_o     = (state_q == S_SEARCH);
    assign search_key_o = slot_q.key;

    // ----------------------------------------------------------
    // slot fsm
    // ----------------------------------------------------------
    always_comb begin
        state_d = state_q;
        hit_wr  = 1'b0;
        alloc_o = 1'b0;
        case (state_q)
            S_IDLE: begin
                if (req_valid_i) begin
                    state_d = S_SEARCH;
                end
            end
            S_SEARCH: begin
                state_d = S_RESOLVE;
            end
            S_RESOLVE: begin
                if (hit_i) begin
                    if (!out_full_i) begin
                        hit_wr  = 1'b1;
                        state_d = S_IDLE;
                    end
                end else if (pending_i) begin
                    // key already in flight so search again
                    state_d = S_SEARCH;
                end else if (free_i && !c2a_full_i) begin
                    alloc_o = 1'b1;
                    state_d = S_IDLE;
                end
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            slot_q <= req_i;
        end
    end

    // miss path
    assign alloc_req_o    = slot_q;
    assign c2a_push_o     = alloc_o;
    assign c2a_data_o.key = slot_q.key;
    assign c2a_data_o.idx = free_idx_i;

    // ----------------------------------------------------------
    // output buffer write with hits ahead of mshr sends
    // ----------------------------------------------------------
    assign send_accept_o = send_valid_i && !out_full_i && !hit_wr;
    assign out_push_o    = hit_wr || send_accept_o;

    always_comb begin
        if (hit_wr) begin
            out_data_o.result = result_i;
            out_data_o.meta   = slot_q.meta;
        end else begin
            out_data_o = send_rsp_i;
        end
    end

endmodule

`default_nettype wire

/* lookup_cache_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lkp_params.svh"

module lookup_cache_top (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      req_valid_i,
    input  wire  lkp_pkg::lkp_req_t  req_i,
    output logic                     req_ready_o,
    output logic                     rsp_valid_o,
    output lkp_pkg::lkp_rsp_t        rsp_o,
    input  wire                      rsp_ready_i,
    output logic                     c2a_vld_o,
    output logic [`LKP_INFO_W-1:0]   c2a_info_o,
    output logic [`LKP_REQ_ID_W-1:0] c2a_req_id_o,
    input  wire                      a2c_rdy_i,
    input  wire                      a2c_rsp_vld_i,
    input  wire  [`LKP_REQ_ID_W-1:0] a2c_rsp_id_i,
    input  wire  [`LKP_RSLT_W-1:0]   a2c_rslt_i
);

    import lkp_pkg::*;

    logic                   search;
    logic [`LKP_INFO_W-1:0] search_key;
    logic                   tag_hit;
    logic [`LKP_RSLT_W-1:0] tag_result;
    logic                   insert;
    logic [`LKP_INFO_W-1:0] insert_key;
    logic [`LKP_RSLT_W-1:0] insert_result;
    logic                   insert_done;
    logic                   pending;
    logic                   free;
    mshr_idx_t              free_idx;
    logic                   alloc;
    lkp_req_t               alloc_req;
    logic                   send_valid;
    lkp_rsp_t               send_rsp;
    logic                   send_accept;
    logic                   c2a_push;
    c2a_req_t               c2a_data;
    logic                   c2a_full;
    c2a_req_t               c2a_head;
    logic                   c2a_empty;
    logic                   out_push;
    lkp_rsp_t               out_data;
    logic                   out_full;
    logic                   out_empty;

    lookup_ctrl u_lookup_ctrl (
        .clk           (clk),
        .rst           (rst),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .req_ready_o   (req_ready_o),
        .search_o      (search),
        .search_key_o  (search_key),
        .hit_i         (tag_hit),
        .result_i      (tag_result),
        .pending_i     (pending),
        .free_i        (free),
        .free_idx_i    (free_idx),
        .alloc_o       (alloc),
        .alloc_req_o   (alloc_req),
        .c2a_push_o    (c2a_push),
        .c2a_data_o    (c2a_data),
        .c2a_full_i    (c2a_full),
        .send_valid_i  (send_valid),
        .send_rsp_i    (send_rsp),
        .send_accept_o (send_accept),
        .out_push_o    (out_push),
        .out_data_o    (out_data),
        .out_full_i    (out_full)
    );

    tag_table u_tag_table (
        .clk             (clk),
        .rst             (rst),
        .search_i        (search),
        .search_key_i    (search_key),
        .hit_o           (tag_hit),
        .result_o        (tag_result),
        .insert_i        (insert),
        .insert_key_i    (insert_key),
        .insert_result_i (insert_result),
        .insert_done_o   (insert_done)
    );

    mshr_file u_mshr_file (
        .clk             (clk),
        .rst             (rst),
        .lookup_key_i    (search_key),
        .pending_o       (pending),
        .free_o          (free),
        .free_idx_o      (free_idx),
        .alloc_i         (alloc),
        .alloc_req_i     (alloc_req),
        .rsp_vld_i       (a2c_rsp_vld_i),
        .rsp_idx_i       (a2c_rsp_id_i[`LKP_MSHR_W-1:0]),
        .rsp_rslt_i      (a2c_rslt_i),
        .insert_o        (insert),
        .insert_key_o    (insert_key),
        .insert_result_o (insert_result),
        .insert_done_i   (insert_done),
        .send_valid_o    (send_valid),
        .send_rsp_o      (send_rsp),
        .send_accept_i   (send_accept)
    );

    sync_fifo #(
        .WIDTH      ($bits(c2a_req_t)),
        .DEPTH_LOG2 (`LKP_C2A_DEPTH_LOG2)
    ) c2a_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr_en_i   (c2a_push),
        .wr_data_i (c2a_data),
        .rd_en_i   (a2c_rdy_i),
        .rd_data_o (c2a_head),
        .full_o    (c2a_full),
        .empty_o   (c2a_empty)
    );

    sync_fifo #(
        .WIDTH      ($bits(lkp_rsp_t)),
        .DEPTH_LOG2 (`LKP_OUT_DEPTH_LOG2)
    ) out_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr_en_i   (out_push),
        .wr_data_i (out_data),
        .rd_en_i   (rsp_ready_i),
        .rd_data_o (rsp_o),
        .full_o    (out_full),
        .empty_o   (out_empty)
    );

    // request id toward A is the zero padded mshr slot
    assign c2a_vld_o    = !c2a_empty;
    assign c2a_info_o   = c2a_head.key;
    assign c2a_req_id_o = {{(`LKP_REQ_ID_W - `LKP_MSHR_W){1'b0}}, c2a_head.idx};
    assign rsp_valid_o  = !out_empty;

endmodule

`default_nettype wire

/* tb_lookup_cache.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lkp_params.svh"

module tb_lookup_cache;

    import lkp_pkg::*;

    localparam int N_REQ   = 200;
    localparam int N_KEYS  = 6;
    localparam int META_W  = $bits(lkp_meta_t);
    localparam int TIMEOUT = N_REQ * 40;
    localparam logic [`LKP_RSLT_W-1:0] RSLT_MASK = 20'h5a5a5;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     req_valid;
    lkp_req_t                 req;
    logic                     req_ready;
    logic                     rsp_valid;
    lkp_rsp_t                 rsp;
    logic                     rsp_ready;
    logic                     c2a_vld;
    logic [`LKP_INFO_W-1:0]   c2a_info;
    logic [`LKP_REQ_ID_W-1:0] c2a_req_id;
    logic                     a2c_rdy;
    logic                     a2c_rsp_vld;
    logic [`LKP_REQ_ID_W-1:0] a2c_rsp_id;
    logic [`LKP_RSLT_W-1:0]   a2c_rslt;

    // scoreboard state per request number, which is also the meta value
    logic [`LKP_INFO_W-1:0]   pool [N_KEYS];
    logic                     accepted [N_REQ];
    logic                     answered [N_REQ];
    logic [`LKP_INFO_W-1:0]   acc_key [N_REQ];
    logic                     key_used [N_KEYS];
    int                       a_req_cnt [N_KEYS];
    logic [`LKP_MSHR_NUM-1:0] id_busy;
    int                       acc_cnt;
    int                       rsp_cnt;

    // handshakes seen at the last rising edge
    logic                     req_fire = 1'b0;
    logic                     a_fire = 1'b0;
    logic [`LKP_MSHR_W-1:0]   a_idx = '0;
    logic [`LKP_INFO_W-1:0]   a_key = '0;

    // module A model
    logic                     a_pend [`LKP_MSHR_NUM];
    int                       a_due [`LKP_MSHR_NUM];
    logic [`LKP_INFO_W-1:0]   a_rkey [`LKP_MSHR_NUM];

    int                       next_req;
    int                       cycle = 0;
    int                       sva_errs = 0;
    int                       mon_errs = 0;
    int                       end_errs = 0;

    lookup_cache_top u_lookup_cache_top (
        .clk           (clk),
        .rst           (rst),
        .req_valid_i   (req_valid),
        .req_i         (req),
        .req_ready_o   (req_ready),
        .rsp_valid_o   (rsp_valid),
        .rsp_o         (rsp),
        .rsp_ready_i   (rsp_ready),
        .c2a_vld_o     (c2a_vld),
        .c2a_info_o    (c2a_info),
        .c2a_req_id_o  (c2a_req_id),
        .a2c_rdy_i     (a2c_rdy),
        .a2c_rsp_vld_i (a2c_rsp_vld),
        .a2c_rsp_id_i  (a2c_rsp_id),
        .a2c_rslt_i    (a2c_rslt)
    );

    always #10 clk = ~clk;

    function automatic int pool_index(input logic [`LKP_INFO_W-1:0] key);
        int idx;
        idx = -1;
        for (int k = 0; k < N_KEYS; k++) begin
            if (pool[k] == key) begin
                idx = k;
            end
        end
        return idx;
    endfunction

    // ------------------------------------------------------------
    // protocol checks
    // ------------------------------------------------------------
    assert property (@(posedge clk) $fell(rst) |-> !rsp_valid)
        else begin
            sva_errs++;
            $display("FAIL t=%0t rsp_valid_o got %b expected 0", $time, $sampled(rsp_valid));
        end

    assert property (@(posedge clk) $fell(rst) |-> !c2a_vld)
        else begin
            sva_errs++;
            $display("FAIL t=%0t c2a_vld_o got %b expected 0", $time, $sampled(c2a_vld));
        end

    assert property (@(posedge clk) $fell(rst) |-> req_ready)
        else begin
            sva_errs++;
            $display("FAIL t=%0t req_ready_o got %b expected 1", $time, $sampled(req_ready));
        end

    assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else begin
            sva_errs++;
            $display("response dropped or changed while stalled at t=%0t", $time);
        end

    assert property (@(posedge clk) disable iff (rst)
        c2a_vld && !a2c_rdy |=> c2a_vld && $stable(c2a_info) && $stable(c2a_req_id))
        else begin
            sva_errs++;
            $display("A request dropped or changed while stalled at t=%0t", $time);
        end

    // ------------------------------------------------------------
    // scoreboard
    // ------------------------------------------------------------
    always @(posedge clk) begin : watch_ports
        int idx;
        int k;
        req_fire = 1'b0;
        a_fire   = 1'b0;
        if (rst) begin
            for (int i = 0; i < N_REQ; i++) begin
                accepted[i] = 1'b0;
                answered[i] = 1'b0;
            end
            for (int i = 0; i < N_KEYS; i++) begin
                key_used[i]  = 1'b0;
                a_req_cnt[i] = 0;
            end
            id_busy = '0;
            acc_cnt = 0;
            rsp_cnt = 0;
        end else begin
            if (req_valid && req_ready) begin
                idx           = int'(req.meta);
                k             = pool_index(req.key);
                req_fire      = 1'b1;
                accepted[idx] = 1'b1;
                acc_key[idx]  = req.key;
                key_used[k]   = 1'b1;
                acc_cnt++;
            end
            if (rsp_valid && rsp_ready) begin
                idx = int'(rsp.meta);
                rsp_cnt++;
                assert (idx < N_REQ && accepted[idx] && !answered[idx]) else begin
                    mon_errs++;
                    $display("response at t=%0t has meta %h of no open request", $time, rsp.meta);
                end
                if (idx < N_REQ) begin
                    assert (rsp.result == (acc_key[idx] ^ RSLT_MASK)) else begin
                        mon_errs++;
                        $display("FAIL t=%0t rsp_o.result got %h expected %h",
                                 $time, rsp.result, acc_key[idx] ^ RSLT_MASK);
                    end
                    answered[idx] = 1'b1;
                end
            end
            // a fill answer frees its id before a new request is looked at
            if (a2c_rsp_vld) begin
                id_busy[a2c_rsp_id[`LKP_MSHR_W-1:0]] = 1'b0;
            end
            if (c2a_vld && a2c_rdy) begin
                a_fire = 1'b1;
                a_idx  = c2a_req_id[`LKP_MSHR_W-1:0];
                a_key  = c2a_info;
                k      = pool_index(c2a_info);
                assert (c2a_req_id[`LKP_REQ_ID_W-1:`LKP_MSHR_W] == '0 && !id_busy[a_idx])
                else begin
                    mon_errs++;
                    $display("A request id %0d at t=%0t is out of range or still in use",
                             c2a_req_id, $time);
                end
                assert (k >= 0) else begin
                    mon_errs++;
                    $display("A request at t=%0t for key %h outside the pool", $time, c2a_info);
                end
                if (k >= 0) begin
                    assert (a_req_cnt[k] == 0) else begin
                        mon_errs++;
                        $display("FAIL t=%0t a_req_cnt[%0d] got %0d expected 0",
                                 $time, k, a_req_cnt[k]);
                    end
                    a_req_cnt[k]++;
                end
                id_busy[a_idx] = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) begin
            $display("timeout after %0d cycles with %0d of %0d responses", cycle, rsp_cnt, N_REQ);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // stimulus driven on the falling edge
    // ------------------------------------------------------------
    task automatic drive_execute();
        int kidx;
        if (req_fire) begin
            next_req++;
        end
        if (!req_valid || req_fire) begin
            kidx      = int'($urandom_range(N_KEYS - 1, 0));
            req_valid = (next_req < N_REQ) && ($urandom_range(3, 0) != 0);
            req.key   = pool[kidx];
            req.meta  = META_W'(next_req);
        end
        rsp_ready = ($urandom_range(3, 0) != 0);
    endtask

    task automatic drive_engine();
        if (a_fire) begin
            a_pend[a_idx] = 1'b1;
            a_due[a_idx]  = cycle + int'($urandom_range(10, 2));
            a_rkey[a_idx] = a_key;
        end
        a2c_rsp_vld = 1'b0;
        for (int i = 0; i < `LKP_MSHR_NUM; i++) begin
            if (!a2c_rsp_vld && a_pend[i] && a_due[i] <= cycle) begin
                a2c_rsp_vld = 1'b1;
                a2c_rsp_id  = `LKP_REQ_ID_W'(i);
                a2c_rslt    = a_rkey[i] ^ RSLT_MASK;
                a_pend[i]   = 1'b0;
            end
        end
        a2c_rdy = ($urandom_range(1, 0) == 1);
    endtask

    initial begin
        logic [31:0] rnd;
        void'($urandom(32'h4b84f98e));
        rst         = 1'b1;
        req_valid   = 1'b0;
        req         = '0;
        rsp_ready   = 1'b0;
        a2c_rdy     = 1'b0;
        a2c_rsp_vld = 1'b0;
        a2c_rsp_id  = '0;
        a2c_rslt    = '0;
        next_req    = 0;
        // low nibble keeps the pool keys distinct
        for (int i = 0; i < N_KEYS; i++) begin
            rnd     = $urandom();
            pool[i] = {rnd[15:0], 4'(i)};
        end
        for (int i = 0; i < `LKP_MSHR_NUM; i++) begin
            a_pend[i] = 1'b0;
            a_due[i]  = 0;
            a_rkey[i] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);
        while (rsp_cnt < N_REQ) begin
            @(negedge clk);
            drive_execute();
            drive_engine();
        end
        // drain so that a late extra response still reaches the scoreboard
        req_valid   = 1'b0;
        rsp_ready   = 1'b1;
        a2c_rdy     = 1'b1;
        a2c_rsp_vld = 1'b0;
        repeat (20) @(negedge clk);

        for (int i = 0; i < N_KEYS; i++) begin
            if (key_used[i]) begin
                assert (a_req_cnt[i] == 1) else begin
                    end_errs++;
                    $display("FAIL t=%0t a_req_cnt[%0d] got %0d expected 1",
                             $time, i, a_req_cnt[i]);
                end
            end
        end
        for (int i = 0; i < N_REQ; i++) begin
            assert (accepted[i] && answered[i]) else begin
                end_errs++;
                $display("request %0d was never accepted or never answered", i);
            end
        end

        $display("summary: %0d accepted, %0d responses, errors %0d assertion %0d scoreboard %0d end",
                 acc_cnt, rsp_cnt, sva_errs, mon_errs, end_errs);
        if (sva_errs + mon_errs + end_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
lkp_pkg.sv
sync_fifo.sv
tag_table.sv
mshr_file.sv
lookup_ctrl.sv
lookup_cache_top.sv
tb_lookup_cache.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_lookup_cache
FLIST     = all.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(filter-out +incdir+%,$(shell cat $(FLIST))) lkp_params.svh

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -qxF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
